// File: hdl/cia_regs_pkg.sv
`default_nettype none

package cia_regs_pkg;

    typedef logic [3:0] reg_addr_t;

    // Register map.
    localparam reg_addr_t REG_PRA      = 4'h0;
    localparam reg_addr_t REG_PRB      = 4'h1;
    localparam reg_addr_t REG_DDRA     = 4'h2;
    localparam reg_addr_t REG_DDRB     = 4'h3;
    localparam reg_addr_t REG_TA_LO    = 4'h4;
    localparam reg_addr_t REG_TA_HI    = 4'h5;
    localparam reg_addr_t REG_TB_LO    = 4'h6;
    localparam reg_addr_t REG_TB_HI    = 4'h7;
    // TOD and serial slots are kept reserved and read zero.
    localparam reg_addr_t REG_TOD_10TH = 4'h8;
    localparam reg_addr_t REG_TOD_SEC  = 4'h9;
    localparam reg_addr_t REG_TOD_MIN  = 4'ha;
    localparam reg_addr_t REG_TOD_HR   = 4'hb;
    localparam reg_addr_t REG_SDR      = 4'hc;
    localparam reg_addr_t REG_ICR      = 4'hd;
    localparam reg_addr_t REG_CRA      = 4'he;
    localparam reg_addr_t REG_CRB      = 4'hf;

    localparam int TIMER_W = 16;
    localparam int PORT_W  = 8;

    // Interrupt sources and their ICR positions.
    localparam int ICR_SRC_W = 5;
    localparam int ICR_TA    = 0;
    localparam int ICR_TB    = 1;
    localparam int ICR_FLG   = 4;

    // Sources that exist in this core.
    localparam logic [ICR_SRC_W-1:0] ICR_IMPL =
        ICR_SRC_W'((1 << ICR_TA) | (1 << ICR_TB) | (1 << ICR_FLG));

    // CRA and CRB layout.
    typedef struct packed {
        logic       unused_7;
        logic       cascade;
        logic       unused_5;
        logic       force_load;
        logic       oneshot;
        logic [1:0] unused_2_1;
        logic       running;
    } cr_word_t;

    // ICR write layout.
    typedef struct packed {
        logic                 set_clear;
        logic [1:0]           unused_6_5;
        logic [ICR_SRC_W-1:0] src;
    } icr_word_t;

    // One written byte, seen as CR or ICR by address.
    typedef union packed {
        cr_word_t  cr;
        icr_word_t icr;
    } ctrl_word_u;

endpackage

`default_nettype wire

// File: hdl/cia_bus_pkg.sv
`default_nettype none

package cia_bus_pkg;

    typedef struct packed {
        logic                     cs;
        logic                     we;
        cia_regs_pkg::reg_addr_t  addr;
        logic [7:0]               wdata;
    } bus_req_t;

    // One strobe per implemented register.
    typedef struct packed {
        logic                     pra;
        logic                     prb;
        logic                     ddra;
        logic                     ddrb;
        logic                     ta_lo;
        logic                     ta_hi;
        logic                     tb_lo;
        logic                     tb_hi;
        logic                     icr;
        logic                     cra;
        logic                     crb;
        cia_regs_pkg::ctrl_word_u wdata;
    } reg_wr_t;

    typedef struct packed {
        logic ta_uf;
        logic tb_uf;
        logic flag;
    } irq_events_t;

    function automatic logic bus_wr_hit(bus_req_t req, cia_regs_pkg::reg_addr_t addr);
        return req.cs && req.we && (req.addr == addr);
    endfunction

    function automatic logic bus_rd_hit(bus_req_t req, cia_regs_pkg::reg_addr_t addr);
        return req.cs && !req.we && (req.addr == addr);
    endfunction

    // Places event pulses on their ICR bits.
    function automatic logic [cia_regs_pkg::ICR_SRC_W-1:0] ev_to_src(irq_events_t ev);
        logic [cia_regs_pkg::ICR_SRC_W-1:0] src;
        src = '0;
        src[cia_regs_pkg::ICR_TA]  = ev.ta_uf;
        src[cia_regs_pkg::ICR_TB]  = ev.tb_uf;
        src[cia_regs_pkg::ICR_FLG] = ev.flag;
        return src;
    endfunction

endpackage

`default_nettype wire

// File: hdl/cia_bus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module cia_bus_decode (
    input  cia_bus_pkg::bus_req_t                bus_req,
    output cia_bus_pkg::reg_wr_t                 reg_wr,
    output logic                                 icr_rd,
    output logic                                 prb_acc,
    input  logic [cia_regs_pkg::PORT_W-1:0]      port_rd_a,
    input  logic [cia_regs_pkg::PORT_W-1:0]      port_rd_b,
    input  logic [cia_regs_pkg::PORT_W-1:0]      ddra,
    input  logic [cia_regs_pkg::PORT_W-1:0]      ddrb,
    input  logic [cia_regs_pkg::TIMER_W-1:0]     ta_count,
    input  logic [cia_regs_pkg::TIMER_W-1:0]     tb_count,
    input  logic [7:0]                           cra,
    input  logic [7:0]                           crb,
    input  logic [7:0]                           icr_status,
    output logic [7:0]                           rd_data
);
    import cia_regs_pkg::*;
    import cia_bus_pkg::*;

    // Write strobes, one per register.
    always_comb begin
        reg_wr.pra   = bus_wr_hit(bus_req, REG_PRA);
        reg_wr.prb   = bus_wr_hit(bus_req, REG_PRB);
        reg_wr.ddra  = bus_wr_hit(bus_req, REG_DDRA);
        reg_wr.ddrb  = bus_wr_hit(bus_req, REG_DDRB);
        reg_wr.ta_lo = bus_wr_hit(bus_req, REG_TA_LO);
        reg_wr.ta_hi = bus_wr_hit(bus_req, REG_TA_HI);
        reg_wr.tb_lo = bus_wr_hit(bus_req, REG_TB_LO);
        reg_wr.tb_hi = bus_wr_hit(bus_req, REG_TB_HI);
        reg_wr.icr   = bus_wr_hit(bus_req, REG_ICR);
        reg_wr.cra   = bus_wr_hit(bus_req, REG_CRA);
        reg_wr.crb   = bus_wr_hit(bus_req, REG_CRB);
        reg_wr.wdata = bus_req.wdata;
    end

    // Read side effect on the ICR.
    assign icr_rd = bus_rd_hit(bus_req, REG_ICR);

    // Port B strobe fires on reads and writes alike.
    assign prb_acc = bus_req.cs && (bus_req.addr == REG_PRB);

    // Read mux, follows the address only.
    always_comb begin
        rd_data = '0;
        case (bus_req.addr)
            REG_PRA:      rd_data = port_rd_a;
            REG_PRB:      rd_data = port_rd_b;
            REG_DDRA:     rd_data = ddra;
            REG_DDRB:     rd_data = ddrb;
            REG_TA_LO:    rd_data = ta_count[7:0];
            REG_TA_HI:    rd_data = ta_count[TIMER_W-1:8];
            REG_TB_LO:    rd_data = tb_count[7:0];
            REG_TB_HI:    rd_data = tb_count[TIMER_W-1:8];
            REG_TOD_10TH: rd_data = '0;
            REG_TOD_SEC:  rd_data = '0;
            REG_TOD_MIN:  rd_data = '0;
            REG_TOD_HR:   rd_data = '0;
            REG_SDR:      rd_data = '0;
            REG_ICR:      rd_data = icr_status;
            REG_CRA:      rd_data = cra;
            REG_CRB:      rd_data = crb;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cia_io_ports.sv
`default_nettype none
`timescale 1ns/1ps

module cia_io_ports (
    input  logic                             CNT,
    input  logic                             RESET_n,
    input  cia_bus_pkg::reg_wr_t             reg_wr,
    input  logic                             prb_acc,
    input  logic [cia_regs_pkg::PORT_W-1:0]  pa_in,
    input  logic [cia_regs_pkg::PORT_W-1:0]  pb_in,
    input  logic                             flag_n,
    output logic [cia_regs_pkg::PORT_W-1:0]  pa_out,
    output logic [cia_regs_pkg::PORT_W-1:0]  pa_oe,
    output logic [cia_regs_pkg::PORT_W-1:0]  pb_out,
    output logic [cia_regs_pkg::PORT_W-1:0]  pb_oe,
    output logic [cia_regs_pkg::PORT_W-1:0]  port_rd_a,
    output logic [cia_regs_pkg::PORT_W-1:0]  port_rd_b,
    output logic [cia_regs_pkg::PORT_W-1:0]  ddra,
    output logic [cia_regs_pkg::PORT_W-1:0]  ddrb,
    output logic                             pc_n,
    output logic                             flag_ev
);
    import cia_regs_pkg::*;

    logic [PORT_W-1:0] pra_q;
    logic [PORT_W-1:0] prb_q;
    logic [PORT_W-1:0] ddra_q;
    logic [PORT_W-1:0] ddrb_q;
    logic              pc_q;
    logic              flag_s1;
    logic              flag_s2;

    // Data and direction registers.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pra_q  <= '0;
            prb_q  <= '0;
            ddra_q <= '0;
            ddrb_q <= '0;
        end else begin
            if (reg_wr.pra) pra_q <= reg_wr.wdata;
            if (reg_wr.prb) prb_q <= reg_wr.wdata;
            if (reg_wr.ddra) ddra_q <= reg_wr.wdata;
            if (reg_wr.ddrb) ddrb_q <= reg_wr.wdata;
        end
    end

    // PC strobe one cycle after a port B access; FLAG sampled twice.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pc_q    <= 1'b0;
            flag_s1 <= 1'b1;
            flag_s2 <= 1'b1;
        end else begin
            pc_q    <= prb_acc;
            flag_s1 <= flag_n;
            flag_s2 <= flag_s1;
        end
    end

    assign pa_out    = pra_q;
    assign pa_oe     = ddra_q;
    assign pb_out    = prb_q;
    assign pb_oe     = ddrb_q;
    assign ddra      = ddra_q;
    assign ddrb      = ddrb_q;
    // Reads see the pins.
    assign port_rd_a = pa_in;
    assign port_rd_b = pb_in;
    assign pc_n      = ~pc_q;
    assign flag_ev   = flag_s2 && !flag_s1;

endmodule

`default_nettype wire

// File: hdl/cia_interval_timer.sv
`default_nettype none
`timescale 1ns/1ps

module cia_interval_timer #(
    parameter bit CAN_CASCADE = 1'b0
) (
    input  logic                              CNT,
    input  logic                              RESET_n,
    input  logic                              wr_lo,
    input  logic                              wr_hi,
    input  logic                              wr_cr,
    input  cia_regs_pkg::ctrl_word_u          wdata,
    input  logic                              cascade_tick,
    output logic [cia_regs_pkg::TIMER_W-1:0]  count,
    output logic [7:0]                        cr_rd,
    output logic                              underflow
);
    import cia_regs_pkg::*;

    logic [TIMER_W-1:0] latch_q;
    logic [TIMER_W-1:0] count_q;
    logic               running_q;
    logic               oneshot_q;
    logic               cascade_q;
    logic               step;
    cr_word_t           cr_view;

    // Counts every edge, or only on ticks in cascade mode.
    assign step      = running_q && (!cascade_q || cascade_tick);
    assign underflow = step && (count_q == '0);

    // Reload latch.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            latch_q <= '0;
        end else begin
            if (wr_lo) latch_q[7:0] <= wdata;
            if (wr_hi) latch_q[TIMER_W-1:8] <= wdata;
        end
    end

    // Force load first, then HI write while stopped, then counting.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            count_q <= '0;
        end else if (wr_cr && wdata.cr.force_load) begin
            count_q <= latch_q;
        end else if (wr_hi && !running_q) begin
            count_q <= {wdata, latch_q[7:0]};
        end else if (underflow) begin
            count_q <= latch_q;
        end else if (step) begin
            count_q <= count_q - TIMER_W'(1);
        end
    end

    // Control bits.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            running_q <= 1'b0;
            oneshot_q <= 1'b0;
            cascade_q <= 1'b0;
        end else if (wr_cr) begin
            running_q <= wdata.cr.running;
            oneshot_q <= wdata.cr.oneshot;
            cascade_q <= CAN_CASCADE && wdata.cr.cascade;
        end else if (underflow && oneshot_q) begin
            running_q <= 1'b0;
        end
    end

    // Readback, force_load always zero.
    always_comb begin
        cr_view         = '0;
        cr_view.running = running_q;
        cr_view.oneshot = oneshot_q;
        cr_view.cascade = cascade_q;
    end

    assign cr_rd = cr_view;
    assign count = count_q;

endmodule

`default_nettype wire

// File: hdl/cia_irq_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module cia_irq_ctrl (
    input  logic                      CNT,
    input  logic                      RESET_n,
    input  logic                      wr_icr,
    input  cia_regs_pkg::ctrl_word_u  wdata,
    input  logic                      icr_rd,
    input  cia_bus_pkg::irq_events_t  events,
    output logic [7:0]                icr_status,
    output logic                      irq_n
);
    import cia_regs_pkg::*;
    import cia_bus_pkg::*;

    logic [ICR_SRC_W-1:0] mask_q;
    logic [ICR_SRC_W-1:0] flags_q;
    logic [ICR_SRC_W-1:0] ev_src;
    logic                 irq;

    assign ev_src = ev_to_src(events);

    // Mask set or clear, unimplemented sources never set.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            mask_q <= '0;
        end else if (wr_icr) begin
            if (wdata.icr.set_clear) mask_q <= mask_q | (wdata.icr.src & ICR_IMPL);
            else mask_q <= mask_q & ~wdata.icr.src;
        end
    end

    // Sticky events; a read keeps only this cycle's new ones.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            flags_q <= '0;
        end else if (icr_rd) begin
            flags_q <= ev_src;
        end else begin
            flags_q <= flags_q | ev_src;
        end
    end

    assign irq        = |(flags_q & mask_q);
    assign irq_n      = ~irq;
    assign icr_status = {irq, 2'b00, flags_q};

endmodule

`default_nettype wire

// File: hdl/cia_top.sv
`default_nettype none
`timescale 1ns/1ps

module cia_top (
    input  logic                             CNT,
    input  logic                             RESET_n,
    input  cia_bus_pkg::bus_req_t            bus_req,
    output logic [7:0]                       rd_data,
    input  logic [cia_regs_pkg::PORT_W-1:0]  pa_in,
    input  logic [cia_regs_pkg::PORT_W-1:0]  pb_in,
    output logic [cia_regs_pkg::PORT_W-1:0]  pa_out,
    output logic [cia_regs_pkg::PORT_W-1:0]  pa_oe,
    output logic [cia_regs_pkg::PORT_W-1:0]  pb_out,
    output logic [cia_regs_pkg::PORT_W-1:0]  pb_oe,
    input  logic                             flag_n,
    output logic                             pc_n,
    output logic                             irq_n
);
    import cia_regs_pkg::*;
    import cia_bus_pkg::*;

    reg_wr_t            reg_wr;
    logic               icr_rd;
    logic               prb_acc;
    logic [PORT_W-1:0]  port_rd_a;
    logic [PORT_W-1:0]  port_rd_b;
    logic [PORT_W-1:0]  ddra;
    logic [PORT_W-1:0]  ddrb;
    logic [TIMER_W-1:0] ta_count;
    logic [TIMER_W-1:0] tb_count;
    logic [7:0]         cra;
    logic [7:0]         crb;
    logic [7:0]         icr_status;
    logic               ta_uf;
    logic               tb_uf;
    logic               flag_ev;
    irq_events_t        events;

    assign events = '{ta_uf: ta_uf, tb_uf: tb_uf, flag: flag_ev};

    cia_bus_decode i_bus_decode (
        .bus_req    (bus_req),
        .reg_wr     (reg_wr),
        .icr_rd     (icr_rd),
        .prb_acc    (prb_acc),
        .port_rd_a  (port_rd_a),
        .port_rd_b  (port_rd_b),
        .ddra       (ddra),
        .ddrb       (ddrb),
        .ta_count   (ta_count),
        .tb_count   (tb_count),
        .cra        (cra),
        .crb        (crb),
        .icr_status (icr_status),
        .rd_data    (rd_data)
    );

    cia_io_ports i_io_ports (
        .CNT       (CNT),
        .RESET_n   (RESET_n),
        .reg_wr    (reg_wr),
        .prb_acc   (prb_acc),
        .pa_in     (pa_in),
        .pb_in     (pb_in),
        .flag_n    (flag_n),
        .pa_out    (pa_out),
        .pa_oe     (pa_oe),
        .pb_out    (pb_out),
        .pb_oe     (pb_oe),
        .port_rd_a (port_rd_a),
        .port_rd_b (port_rd_b),
        .ddra      (ddra),
        .ddrb      (ddrb),
        .pc_n      (pc_n),
        .flag_ev   (flag_ev)
    );

    // Timer A never cascades.
    cia_interval_timer #(.CAN_CASCADE(1'b0)) i_timer_a (
        .CNT          (CNT),
        .RESET_n      (RESET_n),
        .wr_lo        (reg_wr.ta_lo),
        .wr_hi        (reg_wr.ta_hi),
        .wr_cr        (reg_wr.cra),
        .wdata        (reg_wr.wdata),
        .cascade_tick (1'b0),
        .count        (ta_count),
        .cr_rd        (cra),
        .underflow    (ta_uf)
    );

    // Timer B can count timer A underflows.
    cia_interval_timer #(.CAN_CASCADE(1'b1)) i_timer_b (
        .CNT          (CNT),
        .RESET_n      (RESET_n),
        .wr_lo        (reg_wr.tb_lo),
        .wr_hi        (reg_wr.tb_hi),
        .wr_cr        (reg_wr.crb),
        .wdata        (reg_wr.wdata),
        .cascade_tick (ta_uf),
        .count        (tb_count),
        .cr_rd        (crb),
        .underflow    (tb_uf)
    );

    cia_irq_ctrl i_irq_ctrl (
        .CNT        (CNT),
        .RESET_n    (RESET_n),
        .wr_icr     (reg_wr.icr),
        .wdata      (reg_wr.wdata),
        .icr_rd     (icr_rd),
        .events     (events),
        .icr_status (icr_status),
        .irq_n      (irq_n)
    );

endmodule

`default_nettype wire

// File: verification/cia_chk.sv
`default_nettype none
`timescale 1ns/1ps

module cia_chk (
    input logic                                CNT,
    input logic                                RESET_n,
    input logic                                icr_rd,
    input logic [cia_regs_pkg::ICR_SRC_W-1:0]  ev_src,
    input logic [cia_regs_pkg::ICR_SRC_W-1:0]  mask_q,
    input logic [7:0]                          icr_status,
    input logic                                irq_n
);
    import cia_regs_pkg::*;

    int fail_cnt;

    initial fail_cnt = 0;

    // IRQ line follows the visible status bits and the mask.
    irq_follows_mask: assert property (@(posedge CNT) disable iff (!RESET_n)
        irq_n == !(|(icr_status[ICR_SRC_W-1:0] & mask_q)))
        else begin
            $error("irq_n does not match pending and enabled sources");
            fail_cnt++;
        end

    // A read leaves only the events of that same cycle.
    read_clears_status: assert property (@(posedge CNT) disable iff (!RESET_n)
        icr_rd |=> (icr_status[ICR_SRC_W-1:0] == $past(ev_src)))
        else begin
            $error("ICR status after read holds more than the new events");
            fail_cnt++;
        end

    // TOD alarm and serial sources do not exist.
    no_tod_sdr_bits: assert property (@(posedge CNT)
        icr_status[3:2] == 2'b00)
        else begin
            $error("ICR status bit 2 or 3 is set");
            fail_cnt++;
        end

    reset_irq_high: assert property (@(posedge CNT)
        !RESET_n |-> irq_n)
        else begin
            $error("irq_n low during reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: verification/tb_cia_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cia_top;
    import cia_regs_pkg::*;
    import cia_bus_pkg::*;

    // ICR sources present in this core.
    localparam logic [4:0] SRC_USED = 5'b10011;

    logic        CNT;
    logic        RESET_n;
    bus_req_t    bus_req;
    logic [7:0]  rd_data;
    logic [7:0]  pa_in;
    logic [7:0]  pb_in;
    logic [7:0]  pa_out;
    logic [7:0]  pa_oe;
    logic [7:0]  pb_out;
    logic [7:0]  pb_oe;
    logic        flag_n;
    logic        pc_n;
    logic        irq_n;

    // Reference model state. Index 0 is port or timer A.
    logic [7:0]  m_pr [2];
    logic [7:0]  m_ddr [2];
    logic [15:0] m_latch [2];
    logic [15:0] m_count [2];
    logic        m_run [2];
    logic        m_os [2];
    logic        m_casc [2];
    logic [4:0]  m_mask;
    logic [4:0]  m_flags;
    logic        m_pc;
    logic        m_fs1;
    logic        m_fs2;
    logic [31:0] rng;
    int          err_cnt;
    int          check_cnt;
    int          timeouts;

    cia_top i_cia_top (.*);

    bind cia_irq_ctrl cia_chk i_cia_chk (
        .CNT        (CNT),
        .RESET_n    (RESET_n),
        .icr_rd     (icr_rd),
        .ev_src     (ev_src),
        .mask_q     (mask_q),
        .icr_status (icr_status),
        .irq_n      (irq_n)
    );

    initial CNT = 1'b0;
    always #4 CNT = ~CNT;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t: %s is %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    function automatic logic [7:0] model_read(input reg_addr_t a);
        case (a)
            REG_PRA:   return pa_in;
            REG_PRB:   return pb_in;
            REG_DDRA:  return m_ddr[0];
            REG_DDRB:  return m_ddr[1];
            REG_TA_LO: return m_count[0][7:0];
            REG_TA_HI: return m_count[0][15:8];
            REG_TB_LO: return m_count[1][7:0];
            REG_TB_HI: return m_count[1][15:8];
            REG_ICR:   return {|(m_flags & m_mask), 2'b00, m_flags};
            REG_CRA:   return {1'b0, m_casc[0], 2'b00, m_os[0], 2'b00, m_run[0]};
            REG_CRB:   return {1'b0, m_casc[1], 2'b00, m_os[1], 2'b00, m_run[1]};
            default:   return 8'h00;
        endcase
    endfunction

    // One timer edge. Latch changes last, so loads see its old value.
    task automatic timer_update(input logic t, input logic wr_lo, input logic wr_hi,
                                input logic wr_cr, input logic [7:0] d, input logic step);
        logic uf;
        uf = step && (m_count[t] == 16'h0000);
        if (wr_cr && d[4]) m_count[t] = m_latch[t];
        else if (wr_hi && !m_run[t]) m_count[t] = {d, m_latch[t][7:0]};
        else if (uf) m_count[t] = m_latch[t];
        else if (step) m_count[t] = m_count[t] - 16'd1;
        if (wr_cr) begin
            m_run[t]  = d[0];
            m_os[t]   = d[3];
            m_casc[t] = t && d[6];
        end else if (uf && m_os[t]) begin
            m_run[t] = 1'b0;
        end
        if (wr_lo) m_latch[t][7:0] = d;
        if (wr_hi) m_latch[t][15:8] = d;
    endtask

    task automatic model_step();
        logic       wr;
        reg_addr_t  a;
        logic [7:0] d;
        logic       ta_uf;
        logic       tb_step;
        logic [4:0] ev;
        wr      = bus_req.cs && bus_req.we;
        a       = bus_req.addr;
        d       = bus_req.wdata;
        ta_uf   = m_run[0] && (m_count[0] == 16'h0000);
        tb_step = m_run[1] && (!m_casc[1] || ta_uf);
        ev      = {m_fs2 && !m_fs1, 2'b00, tb_step && (m_count[1] == 16'h0000), ta_uf};
        timer_update(1'b0, wr && a == REG_TA_LO, wr && a == REG_TA_HI, wr && a == REG_CRA,
                     d, m_run[0]);
        timer_update(1'b1, wr && a == REG_TB_LO, wr && a == REG_TB_HI, wr && a == REG_CRB,
                     d, tb_step);
        if (wr && a == REG_PRA) m_pr[0] = d;
        if (wr && a == REG_PRB) m_pr[1] = d;
        if (wr && a == REG_DDRA) m_ddr[0] = d;
        if (wr && a == REG_DDRB) m_ddr[1] = d;
        if (wr && a == REG_ICR) begin
            if (d[7]) m_mask = m_mask | (d[4:0] & SRC_USED);
            else m_mask = m_mask & ~d[4:0];
        end
        if (bus_req.cs && !bus_req.we && a == REG_ICR) m_flags = ev;
        else m_flags = m_flags | ev;
        m_pc  = bus_req.cs && (a == REG_PRB);
        m_fs2 = m_fs1;
        m_fs1 = flag_n;
    endtask

    // Entered 1 ns after a rising edge; returns 1 ns after the next one.
    task automatic bus_cycle(input logic cs, input logic we, input reg_addr_t addr,
                             input logic [7:0] d);
        logic [31:0] r;
        r = next_rand();
        bus_req.cs    = cs;
        bus_req.we    = we;
        bus_req.addr  = addr;
        bus_req.wdata = d;
        pa_in = r[7:0];
        pb_in = r[15:8];
        if (r[18:16] == 3'b000) flag_n = ~flag_n;
        #2;
        compare("rd_data", rd_data, model_read(addr));
        compare("pa_out", pa_out, m_pr[0]);
        compare("pa_oe", pa_oe, m_ddr[0]);
        compare("pb_out", pb_out, m_pr[1]);
        compare("pb_oe", pb_oe, m_ddr[1]);
        compare("pc_n", {7'b0, pc_n}, {7'b0, !m_pc});
        compare("irq_n", {7'b0, irq_n}, {7'b0, !(|(m_flags & m_mask))});
        model_step();
        @(posedge CNT);
        #1;
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [7:0] d);
        bus_cycle(1'b1, 1'b1, addr, d);
    endtask

    task automatic read_reg(input reg_addr_t addr);
        bus_cycle(1'b1, 1'b0, addr, 8'h00);
    endtask

    task automatic wait_irq(input int limit, input string what);
        int n;
        n = 0;
        while (irq_n && n < limit) begin
            bus_cycle(1'b0, 1'b0, REG_PRA, 8'h00);
            n++;
        end
        if (irq_n) begin
            timeouts++;
            $display("Timeout: no interrupt from %s within %0d cycles", what, limit);
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        logic [7:0]  d;
        for (int i = 0; i < cycles; i++) begin
            r = next_rand();
            d = r[15:8];
            // Short timer periods so underflows come often.
            if (r[27:24] == REG_TA_HI || r[27:24] == REG_TB_HI) d = d & 8'h01;
            if (r[27:24] == REG_TA_LO || r[27:24] == REG_TB_LO) d = d & 8'h1f;
            bus_cycle(r[31:30] != 2'b00, r[29], r[27:24], d);
        end
    endtask

    initial begin
        rng       = 32'hc7dc_400a;
        err_cnt   = 0;
        check_cnt = 0;
        timeouts  = 0;
        RESET_n   = 1'b0;
        bus_req   = '0;
        pa_in     = 8'h00;
        pb_in     = 8'h00;
        flag_n    = 1'b1;
        m_pr      = '{8'h00, 8'h00};
        m_ddr     = '{8'h00, 8'h00};
        m_latch   = '{16'h0000, 16'h0000};
        m_count   = '{16'h0000, 16'h0000};
        m_run     = '{1'b0, 1'b0};
        m_os      = '{1'b0, 1'b0};
        m_casc    = '{1'b0, 1'b0};
        m_mask    = 5'b00000;
        m_flags   = 5'b00000;
        m_pc      = 1'b0;
        m_fs1     = 1'b1;
        m_fs2     = 1'b1;
        repeat (10) begin
            @(posedge CNT);
            #1;
            compare("irq_n", {7'b0, irq_n}, 8'h01);
            compare("pc_n", {7'b0, pc_n}, 8'h01);
        end
        RESET_n = 1'b1;

        random_traffic(2000);

        // Timer B counts three timer A underflows in cascade mode.
        write_reg(REG_CRA, 8'h00);
        write_reg(REG_CRB, 8'h00);
        write_reg(REG_ICR, 8'h1f);
        write_reg(REG_TA_LO, 8'h03);
        write_reg(REG_TA_HI, 8'h00);
        write_reg(REG_TB_LO, 8'h02);
        write_reg(REG_TB_HI, 8'h00);
        read_reg(REG_ICR);
        write_reg(REG_ICR, 8'h82);
        write_reg(REG_CRB, 8'h51);
        write_reg(REG_CRA, 8'h11);
        wait_irq(100, "timer B in cascade mode");
        read_reg(REG_ICR);

        // One-shot timer A stops and reads back as not running.
        write_reg(REG_CRA, 8'h00);
        write_reg(REG_CRB, 8'h00);
        write_reg(REG_ICR, 8'h1f);
        write_reg(REG_ICR, 8'h81);
        read_reg(REG_ICR);
        write_reg(REG_CRA, 8'h19);
        wait_irq(100, "timer A in one-shot mode");
        read_reg(REG_CRA);
        read_reg(REG_ICR);

        random_traffic(2000);

        $display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 check_cnt, err_cnt, i_cia_top.i_irq_ctrl.i_cia_chk.fail_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0 &&
            i_cia_top.i_irq_ctrl.i_cia_chk.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/cia_regs_pkg.sv
hdl/cia_bus_pkg.sv
hdl/cia_bus_decode.sv
hdl/cia_io_ports.sv
hdl/cia_interval_timer.sv
hdl/cia_irq_ctrl.sv
hdl/cia_top.sv
verification/cia_chk.sv
verification/tb_cia_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CIA testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cia_top -Mdir obj_dir -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_cia_top)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
